// File: vending_settings.svh
`ifndef VENDING_SETTINGS_SVH
`define VENDING_SETTINGS_SVH

// Drink prices, d0 is the expensive one
`define VEND_PRICE_0 80
`define VEND_PRICE_1 30
`define VEND_PRICE_2 25
`define VEND_PRICE_3 20

// Coin button values
`define VEND_COIN_LO  5
`define VEND_COIN_MID 10
`define VEND_COIN_HI  50

`define VEND_CREDIT_MAX  100
`define VEND_REFUND_STEP 5

// Short timer lengths for simulation
`define VEND_DWELL_CYCLES 16
`define VEND_STEP_CYCLES  4

`define VEND_DEBOUNCE_DEPTH 4
`define VEND_SCAN_BITS      2

`endif

// File: vend_pkg.sv
package vend_pkg;

    typedef logic [6:0] credit_t;

    // One bit per coin button
    typedef struct packed {
        logic hi;
        logic mid;
        logic lo;
    } coin_t;

    // d0 is the 80 item
    typedef struct packed {
        logic d3;
        logic d2;
        logic d1;
        logic d0;
    } drink_t;

    // Drink keys and cancel share one conditioner
    typedef struct packed {
        logic   cancel;
        drink_t drink;
    } sel_t;

    // Bit i lit while drink i is affordable
    typedef logic [3:0] lamp_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_VEND   = 2'b01,
        ST_REFUND = 2'b10
    } vend_state_t;

endpackage

// File: disp_pkg.sv
package disp_pkg;

    // 0 to 9 are digits, 10 is blank
    typedef logic [3:0] digit_t;

    // Active low, dot in bit 0
    typedef logic [7:0] seg_t;

    // Active low, one per digit
    typedef logic [3:0] anode_t;

    typedef logic [1:0] scan_pos_t;

    localparam digit_t DIGIT_BLANK = 4'd10;
    localparam seg_t   SEG_BLANK   = 8'hff;
    localparam anode_t ANODE_OFF   = 4'hf;

endpackage

// File: button_conditioner.sv
`timescale 1ns/10ps
`include "vending_settings.svh"

module button_conditioner #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_op,
    input  payload_t raw,
    output payload_t pulse
);

    localparam int W     = $bits(payload_t);
    localparam int DEPTH = `VEND_DEBOUNCE_DEPTH;

    logic [W-1:0]     raw_bits;
    logic [DEPTH-1:0] hist [W];
    logic [W-1:0]     stable;
    logic [W-1:0]     stable_d;
    logic [W-1:0]     pulse_bits;

    assign raw_bits = raw;
    assign pulse    = payload_t'(pulse_bits);

    // Pressed only once every stage agrees
    always_comb begin
        for (int i = 0; i < W; i++) begin
            stable[i] = &hist[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_op) begin
            for (int i = 0; i < W; i++) begin
                hist[i] <= '0;
            end
            stable_d   <= '0;
            pulse_bits <= '0;
        end else begin
            for (int i = 0; i < W; i++) begin
                hist[i] <= {hist[i][DEPTH-2:0], raw_bits[i]};
            end
            stable_d   <= stable;
            pulse_bits <= stable & ~stable_d;
        end
    end

    assert property (@(posedge clk) disable iff (rst_op)
        (pulse_bits & $past(pulse_bits)) == '0)
        else $error("button_conditioner: pulse high for two cycles");

endmodule

// File: vend_fsm.sv
`timescale 1ns/10ps

module vend_fsm (
    input  logic                  clk,
    input  logic                  rst_op,
    input  vend_pkg::coin_t       coin_pulse,
    input  vend_pkg::sel_t        sel_pulse,
    input  vend_pkg::drink_t      afford,
    input  logic                  credit_zero,
    input  logic                  dwell_done,
    input  logic                  step_tick,
    output vend_pkg::vend_state_t state,
    output vend_pkg::drink_t      buy,
    output logic                  refund_step,
    output logic                  accept_coins,
    output logic                  timer_start
);

    import vend_pkg::*;

    vend_state_t next_state;
    logic        coin_any;
    logic [3:0]  req;
    logic [3:0]  pick;

    // A coin in the same cycle as a key takes the credit update
    assign coin_any = |coin_pulse;
    assign req      = sel_pulse.drink & afford;
    assign pick     = req & (~req + 4'd1);

    assign buy          = (state == ST_IDLE && !coin_any) ? drink_t'(pick) : '0;
    assign refund_step  = (state == ST_REFUND) && step_tick;
    assign accept_coins = (state == ST_IDLE);

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (|buy) begin
                    next_state = ST_VEND;
                end else if (sel_pulse.cancel && !coin_any) begin
                    next_state = ST_REFUND;
                end
            end
            ST_VEND: begin
                if (dwell_done) begin
                    next_state = ST_REFUND;
                end
            end
            ST_REFUND: begin
                // Exit only on a step, so an empty refund still takes one
                if (step_tick && credit_zero) begin
                    next_state = ST_IDLE;
                end
            end
            default: begin
                next_state = ST_IDLE;
            end
        endcase
    end

    // Timer start lands in the first cycle of the new state
    always_ff @(posedge clk) begin
        if (rst_op) begin
            state       <= ST_IDLE;
            timer_start <= 1'b0;
        end else begin
            state       <= next_state;
            timer_start <= (next_state != state) && (next_state != ST_IDLE);
        end
    end

    assert property (@(posedge clk) disable iff (rst_op)
        $onehot0(buy))
        else $error("vend_fsm: buy not one-hot");

endmodule

// File: dwell_timer.sv
`timescale 1ns/10ps
`include "vending_settings.svh"

module dwell_timer (
    input  logic                  clk,
    input  logic                  rst_op,
    input  logic                  start,
    input  vend_pkg::vend_state_t state,
    output logic                  dwell_done,
    output logic                  step_tick
);

    import vend_pkg::*;

    localparam int LEN_MAX = (`VEND_DWELL_CYCLES > `VEND_STEP_CYCLES) ?
                             `VEND_DWELL_CYCLES : `VEND_STEP_CYCLES;
    localparam int CNT_W   = $clog2(LEN_MAX + 1);

    localparam logic [CNT_W-1:0] DWELL_LOAD = CNT_W'(`VEND_DWELL_CYCLES - 1);
    localparam logic [CNT_W-1:0] STEP_LOAD  = CNT_W'(`VEND_STEP_CYCLES - 1);

    logic [CNT_W-1:0] cnt;
    logic             expired;

    // Counter still holds zero from idle in the load cycle
    assign expired    = !start && (cnt == '0);
    assign dwell_done = expired && (state == ST_VEND);
    assign step_tick  = expired && (state == ST_REFUND);

    always_ff @(posedge clk) begin
        if (rst_op) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= (state == ST_VEND) ? DWELL_LOAD : STEP_LOAD;
        end else begin
            case (state)
                ST_VEND: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_REFUND: begin
                    cnt <= (cnt == '0) ? STEP_LOAD : cnt - 1'b1;
                end
                default: begin
                    cnt <= '0;
                end
            endcase
        end
    end

endmodule

// File: credit_unit.sv
`timescale 1ns/10ps
`include "vending_settings.svh"

module credit_unit (
    input  logic              clk,
    input  logic              rst_op,
    input  vend_pkg::coin_t   coin_pulse,
    input  logic              accept_coins,
    input  vend_pkg::drink_t  buy,
    input  logic              refund_step,
    output vend_pkg::credit_t credit,
    output vend_pkg::drink_t  afford,
    output vend_pkg::lamp_t   lamps,
    output logic              credit_zero,
    output logic              coin_return
);

    import vend_pkg::*;

    localparam credit_t CREDIT_MAX = credit_t'(`VEND_CREDIT_MAX);
    localparam credit_t STEP       = credit_t'(`VEND_REFUND_STEP);
    localparam credit_t PRICE_0    = credit_t'(`VEND_PRICE_0);
    localparam credit_t PRICE_1    = credit_t'(`VEND_PRICE_1);
    localparam credit_t PRICE_2    = credit_t'(`VEND_PRICE_2);
    localparam credit_t PRICE_3    = credit_t'(`VEND_PRICE_3);

    credit_t    coin_val;
    credit_t    price;
    credit_t    next_credit;
    logic [7:0] coin_sum;
    logic [3:0] at_least;

    // ========================================================================
    // Lamps and afford
    // ========================================================================
    assign at_least[0] = (credit >= PRICE_0);
    assign at_least[1] = (credit >= PRICE_1);
    assign at_least[2] = (credit >= PRICE_2);
    assign at_least[3] = (credit >= PRICE_3);

    assign afford      = drink_t'(at_least);
    assign lamps       = at_least;
    assign credit_zero = (credit == '0);

    // ========================================================================
    // Money register
    // ========================================================================
    // Lowest coin wins
    assign coin_val = coin_pulse.lo  ? credit_t'(`VEND_COIN_LO)  :
                      coin_pulse.mid ? credit_t'(`VEND_COIN_MID) :
                      coin_pulse.hi  ? credit_t'(`VEND_COIN_HI)  : '0;

    assign price = buy.d0 ? PRICE_0 :
                   buy.d1 ? PRICE_1 :
                   buy.d2 ? PRICE_2 :
                   buy.d3 ? PRICE_3 : '0;

    // Wide enough for 100 + 50
    assign coin_sum = {1'b0, credit} + {1'b0, coin_val};

    always_comb begin
        next_credit = credit;
        if (|buy) begin
            next_credit = credit - price;
        end else if (refund_step) begin
            next_credit = (credit >= STEP) ? credit - STEP : '0;
        end else if (accept_coins && |coin_pulse) begin
            next_credit = (coin_sum > {1'b0, CREDIT_MAX}) ? CREDIT_MAX : coin_sum[6:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_op) begin
            credit      <= '0;
            coin_return <= 1'b0;
        end else begin
            credit      <= next_credit;
            coin_return <= refund_step && !credit_zero;
        end
    end

    assert property (@(posedge clk) disable iff (rst_op)
        credit <= CREDIT_MAX)
        else $error("credit_unit: credit above cap");

endmodule

// File: seg_scan.sv
`timescale 1ns/10ps
`include "vending_settings.svh"

module seg_scan (
    input  logic              clk,
    input  logic              rst_op,
    input  vend_pkg::credit_t credit,
    output disp_pkg::anode_t  an,
    output disp_pkg::seg_t    seg
);

    import disp_pkg::*;

    localparam int SCAN_BITS = `VEND_SCAN_BITS;

    logic [SCAN_BITS-1:0] div_cnt;
    logic                 scan_tick;
    scan_pos_t            pos;
    digit_t               ones;
    digit_t               tens;
    digit_t               hundreds;
    digit_t               cur_digit;

    function automatic seg_t seg_of(digit_t d);
        case (d)
            4'd0:    return 8'b0000_0011;
            4'd1:    return 8'b1001_1111;
            4'd2:    return 8'b0010_0101;
            4'd3:    return 8'b0000_1101;
            4'd4:    return 8'b1001_1001;
            4'd5:    return 8'b0100_1001;
            4'd6:    return 8'b0100_0001;
            4'd7:    return 8'b0001_1011;
            4'd8:    return 8'b0000_0001;
            4'd9:    return 8'b0000_1001;
            default: return SEG_BLANK;
        endcase
    endfunction

    // ========================================================================
    // Digit split, leading zeros stay blank
    // ========================================================================
    assign ones     = digit_t'(credit % 10);
    assign tens     = (credit >= 7'd100) ? digit_t'((credit / 10) % 10) :
                      (credit > 7'd9)    ? digit_t'(credit / 10) : DIGIT_BLANK;
    assign hundreds = (credit >= 7'd100) ? digit_t'(credit / 100) : DIGIT_BLANK;

    always_comb begin
        case (pos)
            2'd0:    cur_digit = ones;
            2'd1:    cur_digit = tens;
            2'd2:    cur_digit = hundreds;
            default: cur_digit = DIGIT_BLANK;
        endcase
    end

    // ========================================================================
    // Scanner
    // ========================================================================
    assign scan_tick = (div_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst_op) begin
            div_cnt <= '0;
            pos     <= '0;
            an      <= ANODE_OFF;
            seg     <= SEG_BLANK;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            if (scan_tick) begin
                pos <= pos + 1'b1;
                seg <= seg_of(cur_digit);
                case (pos)
                    2'd0:    an <= 4'b1110;
                    2'd1:    an <= 4'b1101;
                    2'd2:    an <= 4'b1011;
                    default: an <= ANODE_OFF;
                endcase
            end
        end
    end

endmodule

// File: vending_top.sv
`timescale 1ns/10ps

module vending_top (
    input  logic             clk,
    input  logic             rst_op,
    input  vend_pkg::coin_t  coin_btn,
    input  vend_pkg::drink_t drink_btn,
    input  logic             cancel_btn,
    output vend_pkg::lamp_t  lamps,
    output vend_pkg::drink_t dispense,
    output logic             coin_return,
    output disp_pkg::anode_t an,
    output disp_pkg::seg_t   seg
);

    import vend_pkg::*;

    coin_t       coin_pulse;
    sel_t        sel_raw;
    sel_t        sel_pulse;
    drink_t      afford;
    credit_t     credit;
    vend_state_t state;
    logic        credit_zero;
    logic        refund_step;
    logic        accept_coins;
    logic        timer_start;
    logic        dwell_done;
    logic        step_tick;

    assign sel_raw.cancel = cancel_btn;
    assign sel_raw.drink  = drink_btn;

    button_conditioner #(.payload_t(coin_t)) u_coin_cond (
        .clk    (clk),
        .rst_op (rst_op),
        .raw    (coin_btn),
        .pulse  (coin_pulse)
    );

    button_conditioner #(.payload_t(sel_t)) u_drink_cond (
        .clk    (clk),
        .rst_op (rst_op),
        .raw    (sel_raw),
        .pulse  (sel_pulse)
    );

    // Dispense is the buy strobe itself
    vend_fsm u_vend_fsm (
        .clk          (clk),
        .rst_op       (rst_op),
        .coin_pulse   (coin_pulse),
        .sel_pulse    (sel_pulse),
        .afford       (afford),
        .credit_zero  (credit_zero),
        .dwell_done   (dwell_done),
        .step_tick    (step_tick),
        .state        (state),
        .buy          (dispense),
        .refund_step  (refund_step),
        .accept_coins (accept_coins),
        .timer_start  (timer_start)
    );

    dwell_timer u_dwell_timer (
        .clk        (clk),
        .rst_op     (rst_op),
        .start      (timer_start),
        .state      (state),
        .dwell_done (dwell_done),
        .step_tick  (step_tick)
    );

    credit_unit u_credit_unit (
        .clk          (clk),
        .rst_op       (rst_op),
        .coin_pulse   (coin_pulse),
        .accept_coins (accept_coins),
        .buy          (dispense),
        .refund_step  (refund_step),
        .credit       (credit),
        .afford       (afford),
        .lamps        (lamps),
        .credit_zero  (credit_zero),
        .coin_return  (coin_return)
    );

    seg_scan u_seg_scan (
        .clk    (clk),
        .rst_op (rst_op),
        .credit (credit),
        .an     (an),
        .seg    (seg)
    );

endmodule

// File: tb_vending_top.sv
`timescale 1ns/10ps
`include "vending_settings.svh"

module tb_vending_top;

    import vend_pkg::*;
    import disp_pkg::*;

    typedef enum logic [2:0] {
        ACT_WAIT,
        ACT_COIN,
        ACT_DRINK,
        ACT_CANCEL,
        ACT_CANCEL_COIN
    } act_t;

    typedef struct packed {
        act_t    act;
        coin_t   coin;
        drink_t  key;
        credit_t exp_credit;
        drink_t  exp_disp;
        int      exp_returns;
    } step_t;

    localparam coin_t   COIN_NONE    = 3'b000;
    localparam coin_t   COIN_LO      = 3'b001;
    localparam coin_t   COIN_MID     = 3'b010;
    localparam coin_t   COIN_HI      = 3'b100;
    localparam drink_t  KEY_NONE     = 4'b0000;
    localparam drink_t  KEY_0        = 4'b0001;
    localparam drink_t  KEY_1        = 4'b0010;
    localparam drink_t  KEY_2        = 4'b0100;
    localparam drink_t  KEY_3        = 4'b1000;
    localparam int      HOLD_CYCLES  = 8;
    localparam int      QUIET_CYCLES = 4 * (1 << `VEND_SCAN_BITS) + 8;
    localparam credit_t UNREADABLE   = 7'h7f;

    logic   clk = 1'b0;
    logic   rst_op;
    coin_t  coin_btn;
    drink_t drink_btn;
    logic   cancel_btn;
    lamp_t  lamps;
    drink_t dispense;
    logic   coin_return;
    anode_t an;
    seg_t   seg;

    step_t       steps[$];
    logic [31:0] rng;
    int          model_credit;
    int          err_count = 0;
    int          checks_run = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100000;

    // Filled by the output monitor
    int     disp_count = 0;
    int     ret_count = 0;
    drink_t last_disp = '0;
    lamp_t  lamps_seen = '0;
    seg_t   shown [3] = '{SEG_BLANK, SEG_BLANK, SEG_BLANK};

    vending_top u_vending_top (
        .clk         (clk),
        .rst_op      (rst_op),
        .coin_btn    (coin_btn),
        .drink_btn   (drink_btn),
        .cancel_btn  (cancel_btn),
        .lamps       (lamps),
        .dispense    (dispense),
        .coin_return (coin_return),
        .an          (an),
        .seg         (seg)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // Outputs only move on the rising edge
    always @(negedge clk) begin
        if (dispense != '0) begin
            disp_count++;
            last_disp = dispense;
        end
        if (coin_return) begin
            ret_count++;
        end
        lamps_seen = lamps;
        case (an)
            4'b1110: shown[0] = seg;
            4'b1101: shown[1] = seg;
            4'b1011: shown[2] = seg;
            default: begin
            end
        endcase
    end

    // ========================================================================
    // Reference rules
    // ========================================================================
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int price_of(input int idx);
        case (idx)
            0:       return `VEND_PRICE_0;
            1:       return `VEND_PRICE_1;
            2:       return `VEND_PRICE_2;
            default: return `VEND_PRICE_3;
        endcase
    endfunction

    function automatic lamp_t lamps_for(input credit_t c);
        lamp_t l;
        for (int i = 0; i < 4; i++) begin
            l[i] = (int'(c) >= price_of(i));
        end
        return l;
    endfunction

    // Inverse of the display pattern table, 15 for anything unknown
    function automatic digit_t seg_digit(input seg_t s);
        case (s)
            8'b0000_0011: return 4'd0;
            8'b1001_1111: return 4'd1;
            8'b0010_0101: return 4'd2;
            8'b0000_1101: return 4'd3;
            8'b1001_1001: return 4'd4;
            8'b0100_1001: return 4'd5;
            8'b0100_0001: return 4'd6;
            8'b0001_1011: return 4'd7;
            8'b0000_0001: return 4'd8;
            8'b0000_1001: return 4'd9;
            8'b1111_1111: return DIGIT_BLANK;
            default:      return 4'd15;
        endcase
    endfunction

    function automatic credit_t shown_value();
        int ones;
        int tens;
        int hund;
        int v;
        ones = int'(seg_digit(shown[0]));
        tens = int'(seg_digit(shown[1]));
        hund = int'(seg_digit(shown[2]));
        if (ones > 9 || tens > 10 || hund > 10) begin
            return UNREADABLE;
        end
        v = ones + ((tens <= 9) ? 10 * tens : 0) + ((hund <= 9) ? 100 * hund : 0);
        // Leading zeros must be blank
        if ((tens == 10) != (v < 10) || (hund == 10) != (v < 100) || v >= 127) begin
            return UNREADABLE;
        end
        return credit_t'(v);
    endfunction

    function automatic string act_name(input act_t a);
        case (a)
            ACT_COIN:        return "coin";
            ACT_DRINK:       return "drink";
            ACT_CANCEL:      return "cancel";
            ACT_CANCEL_COIN: return "cancel with coin";
            default:         return "wait";
        endcase
    endfunction

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_credit(input credit_t got, input credit_t exp, input int idx);
        checks_run++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d displayed credit %0d, expected %0d",
                     $time, idx, got, exp);
            err_count++;
        end
    endtask

    task automatic check_lamps(input lamp_t got, input lamp_t exp, input int idx);
        checks_run++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d lamps %b, expected %b",
                     $time, idx, got, exp);
            err_count++;
        end
    endtask

    task automatic check_drink(input drink_t got, input drink_t exp, input int idx);
        checks_run++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d dispensed %b, expected %b",
                     $time, idx, got, exp);
            err_count++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what,
                               input int idx);
        checks_run++;
        if (got != exp) begin
            $display("CHECK FAILED at %0t: step %0d saw %0d %s, expected %0d",
                     $time, idx, got, what, exp);
            err_count++;
        end
    endtask

    task automatic check_anode(input anode_t got, input anode_t exp, input int idx);
        checks_run++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d anodes %b, expected %b",
                     $time, idx, got, exp);
            err_count++;
        end
    endtask

    task automatic check_seg(input seg_t got, input seg_t exp, input int idx);
        checks_run++;
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: step %0d segments %b, expected %b",
                     $time, idx, got, exp);
            err_count++;
        end
    endtask

    // ========================================================================
    // Stimulus table
    // ========================================================================
    task automatic add_step(input act_t a, input coin_t c, input drink_t k,
                            input int exp_credit, input drink_t exp_disp, input int exp_ret);
        step_t s;
        s.act         = a;
        s.coin        = c;
        s.key         = k;
        s.exp_credit  = credit_t'(exp_credit);
        s.exp_disp    = exp_disp;
        s.exp_returns = exp_ret;
        steps.push_back(s);
    endtask

    task automatic load_table();
        add_step(ACT_WAIT,        COIN_NONE, KEY_NONE, 0,   KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_LO,   KEY_NONE, 5,   KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_MID,  KEY_NONE, 15,  KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_HI,   KEY_NONE, 65,  KEY_NONE, 0);
        add_step(ACT_DRINK,       COIN_NONE, KEY_0,    65,  KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_HI,   KEY_NONE, 100, KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_LO,   KEY_NONE, 100, KEY_NONE, 0);
        add_step(ACT_DRINK,       COIN_NONE, KEY_0,    0,   KEY_0,    4);
        add_step(ACT_COIN,        COIN_MID,  KEY_NONE, 10,  KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_HI,   KEY_NONE, 60,  KEY_NONE, 0);
        add_step(ACT_DRINK,       COIN_NONE, KEY_2,    0,   KEY_2,    7);
        add_step(ACT_COIN,        COIN_MID,  KEY_NONE, 10,  KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_MID,  KEY_NONE, 20,  KEY_NONE, 0);
        add_step(ACT_DRINK,       COIN_NONE, KEY_1,    20,  KEY_NONE, 0);
        add_step(ACT_DRINK,       COIN_NONE, KEY_3,    0,   KEY_3,    0);
        add_step(ACT_COIN,        COIN_HI,   KEY_NONE, 50,  KEY_NONE, 0);
        add_step(ACT_CANCEL,      COIN_NONE, KEY_NONE, 0,   KEY_NONE, 10);
        add_step(ACT_COIN,        COIN_HI,   KEY_NONE, 50,  KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_HI,   KEY_NONE, 100, KEY_NONE, 0);
        add_step(ACT_CANCEL_COIN, COIN_HI,   KEY_NONE, 0,   KEY_NONE, 20);
        add_step(ACT_CANCEL,      COIN_NONE, KEY_NONE, 0,   KEY_NONE, 0);
        add_step(ACT_COIN,        COIN_MID,  KEY_NONE, 10,  KEY_NONE, 0);
        model_credit = 10;
    endtask

    // Random coins, then one random key, tracked by the reference credit
    task automatic add_random_steps(input int rounds);
        int     n;
        int     pick;
        int     price;
        coin_t  coin;
        drink_t key;
        for (int r = 0; r < rounds; r++) begin
            rng = xorshift(rng);
            n   = 1 + int'(rng % 4);
            for (int j = 0; j < n; j++) begin
                rng  = xorshift(rng);
                pick = int'(rng % 3);
                case (pick)
                    0: begin
                        coin = COIN_LO;
                        model_credit += `VEND_COIN_LO;
                    end
                    1: begin
                        coin = COIN_MID;
                        model_credit += `VEND_COIN_MID;
                    end
                    default: begin
                        coin = COIN_HI;
                        model_credit += `VEND_COIN_HI;
                    end
                endcase
                if (model_credit > `VEND_CREDIT_MAX) begin
                    model_credit = `VEND_CREDIT_MAX;
                end
                add_step(ACT_COIN, coin, KEY_NONE, model_credit, KEY_NONE, 0);
            end
            rng   = xorshift(rng);
            pick  = int'(rng % 4);
            price = price_of(pick);
            key   = drink_t'(4'b0001 << pick);
            if (model_credit >= price) begin
                add_step(ACT_DRINK, COIN_NONE, key, 0, key,
                         (model_credit - price) / `VEND_REFUND_STEP);
                model_credit = 0;
            end else begin
                add_step(ACT_DRINK, COIN_NONE, key, model_credit, KEY_NONE, 0);
            end
        end
    endtask

    // ========================================================================
    // Drivers
    // ========================================================================
    task automatic press_coin(input coin_t c);
        @(negedge clk);
        coin_btn = c;
        repeat (HOLD_CYCLES) @(negedge clk);
        coin_btn = '0;
        repeat (HOLD_CYCLES) @(negedge clk);
    endtask

    task automatic press_sel(input drink_t k, input logic cancel);
        @(negedge clk);
        drink_btn  = k;
        cancel_btn = cancel;
        repeat (HOLD_CYCLES) @(negedge clk);
        drink_btn  = '0;
        cancel_btn = 1'b0;
        repeat (HOLD_CYCLES) @(negedge clk);
    endtask

    task automatic run_step(input step_t s, input int idx);
        int     errs_before;
        int     disp_base;
        int     ret_base;
        int     seen_disp;
        int     seen_ret;
        int     cycles;
        int     limit;
        logic   waiting;
        drink_t seen_drink;
        errs_before = err_count;
        @(posedge clk);
        disp_base = disp_count;
        ret_base  = ret_count;
        case (s.act)
            ACT_COIN:   press_coin(s.coin);
            ACT_DRINK:  press_sel(s.key, 1'b0);
            ACT_CANCEL: press_sel(KEY_NONE, 1'b1);
            ACT_CANCEL_COIN: begin
                press_sel(KEY_NONE, 1'b1);
                press_coin(s.coin);
            end
            default:    repeat (2 * HOLD_CYCLES) @(negedge clk);
        endcase
        limit   = `VEND_DWELL_CYCLES + (s.exp_returns + 2) * `VEND_STEP_CYCLES * 2 + 32;
        cycles  = 0;
        waiting = 1'b1;
        while (waiting) begin
            seen_disp = disp_count - disp_base;
            seen_ret  = ret_count - ret_base;
            if ((s.exp_disp == '0 || seen_disp > 0) && seen_ret >= s.exp_returns) begin
                waiting = 1'b0;
            end else if (cycles >= limit) begin
                $display("Step %0d: dispense or coin_return pulses did not arrive in %0d cycles",
                         idx, limit);
                err_count++;
                waiting = 1'b0;
            end else begin
                @(posedge clk);
                cycles++;
            end
        end
        // Lets the FSM return to idle and the display catch up
        repeat (QUIET_CYCLES) @(posedge clk);
        seen_disp  = disp_count - disp_base;
        seen_ret   = ret_count - ret_base;
        seen_drink = (seen_disp > 0) ? last_disp : KEY_NONE;
        check_drink(seen_drink, s.exp_disp, idx);
        check_count(seen_disp, (s.exp_disp != '0) ? 1 : 0, "dispense pulses", idx);
        check_count(seen_ret, s.exp_returns, "coin_return pulses", idx);
        check_credit(shown_value(), s.exp_credit, idx);
        check_lamps(lamps_seen, lamps_for(s.exp_credit), idx);
        if (err_count == errs_before) begin
            $display("Step %0d %s: passed", idx, act_name(s.act));
        end else begin
            $display("Step %0d %s: failed", idx, act_name(s.act));
        end
    endtask

    initial begin
        rst_op     = 1'b1;
        coin_btn   = '0;
        drink_btn  = '0;
        cancel_btn = 1'b0;
        rng        = 32'h2fcd;
        load_table();
        add_random_steps(6);
        cycle_limit = steps.size() * 64 + 2000;

        repeat (8) @(negedge clk);
        check_anode(an, ANODE_OFF, 0);
        check_seg(seg, SEG_BLANK, 0);
        rst_op = 1'b0;

        foreach (steps[i]) begin
            run_step(steps[i], i);
        end

        $display("Steps: %0d, checks: %0d, failed checks: %0d",
                 steps.size(), checks_run, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: vending_top.f
+incdir+.
vend_pkg.sv
disp_pkg.sv
button_conditioner.sv
vend_fsm.sv
dwell_timer.sv
credit_unit.sv
seg_scan.sv
vending_top.sv
tb_vending_top.sv

// File: Makefile
# Verilator build and run for the vending controller testbench

VERILATOR ?= verilator
TOP       ?= tb_vending_top
FILELIST  ?= vending_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT ?= Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
